//--- src/psram_pkg.sv
//************************************************************
// shared widths, opcodes and bundles for the PSRAM controller
// imported by the RTL blocks and the testbench
//************************************************************
package psram_pkg;

	// widths with a meaning of their own
	typedef logic [23:0] addr_t;   // byte address inside the device
	typedef logic [7:0]  data_t;   // one data byte
	typedef logic [7:0]  opcode_t; // serial command code
	typedef logic [3:0]  credit_t; // credit count, covers depth up to 8

	// SPI-mode command set, single line only
	localparam opcode_t OP_RSTEN = 8'h66; // reset enable
	localparam opcode_t OP_RST   = 8'h99; // reset, must follow RSTEN
	localparam opcode_t OP_READ  = 8'h03; // slow read, no dummy cycles
	localparam opcode_t OP_WRITE = 8'h02; // write

	// client request, one byte per entry
	typedef struct packed {
		logic  write; // 1 = write, 0 = read
		addr_t addr;  // target byte
		data_t wdata; // write byte, ignored for reads
	} psram_req_t;    // 33 bits

	// one transfer framed by a single ce_n low period
	typedef struct packed {
		opcode_t opcode;    // always sent first
		logic    has_addr;  // append 24 address bits
		addr_t   addr;
		logic    has_wdata; // append the write byte
		data_t   wdata;
		logic    read;      // clock in one byte after the address
	} psram_xfer_t;         // 43 bits

endpackage

//--- src/psram_init_seq.sv
//************************************************************
// power-up sequencer, waits then sends RSTEN and RST
// owns the SPI driver until init_done goes high
//************************************************************
`timescale 1ns/1ps

module psram_init_seq #(
	parameter int INIT_WAIT = 12800
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   seq_busy,
	input  logic                   seq_done,
	output logic                   seq_start,
	output psram_pkg::psram_xfer_t seq_xfer,
	output logic                   init_done
);
	import psram_pkg::*;

	// one extra count so the first command lands two cycles after the wait
	localparam int CNT_W = $clog2(INIT_WAIT + 2);
	localparam logic [CNT_W-1:0] WAIT_LOAD = CNT_W'(INIT_WAIT + 1);

	typedef enum logic [1:0] {
		init_wait,  // device power-up delay
		init_rsten, // reset enable in flight
		init_rst,   // reset in flight
		init_ready  // device usable, stays here
	} init_state_t;

	init_state_t      state;
	logic [CNT_W-1:0] wait_cnt; // counts down the power-up delay

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= init_wait;
			wait_cnt  <= WAIT_LOAD;
			seq_start <= 1'b0;
		end else begin
			seq_start <= 1'b0; // single-cycle pulse
			case (state)
				init_wait: begin
					if (wait_cnt != '0) begin
						wait_cnt <= wait_cnt - 1'b1;
					end else if (!seq_busy) begin
						state     <= init_rsten;
						seq_start <= 1'b1; // launch RSTEN
					end
				end
				init_rsten: begin
					if (seq_done) begin
						state     <= init_rst;
						seq_start <= 1'b1; // RST right behind RSTEN
					end
				end
				init_rst: begin
					if (seq_done) state <= init_ready;
				end
				default: ; // init_ready holds until reset
			endcase
		end
	end

	// bare command, only the opcode differs
	always_comb begin
		seq_xfer        = '0;
		seq_xfer.opcode = (state == init_rst) ? OP_RST : OP_RSTEN;
	end

	assign init_done = (state == init_ready); // sticky until rst_n

endmodule

//--- src/psram_spi_driver.sv
//************************************************************
// SPI mode 0 serializer, one ce_n frame per transfer
// sclk at half of clk, MSB first, miso sampled on rising sclk
//************************************************************
`timescale 1ns/1ps

module psram_spi_driver (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   xfer_start,
	input  psram_pkg::psram_xfer_t xfer,
	output logic                   xfer_busy,
	output logic                   xfer_done,
	output psram_pkg::data_t       xfer_rdata,
	output logic                   ce_n,
	output logic                   sclk,
	output logic                   mosi,
	input  logic                   miso
);
	import psram_pkg::*;

	localparam int OW      = $bits(opcode_t);
	localparam int AW      = $bits(addr_t);
	localparam int DW      = $bits(data_t);
	localparam int SHIFT_W = OW + AW + DW;       // longest frame, 40 bits
	localparam int CNT_W   = $clog2(SHIFT_W + 1);

	typedef enum logic [1:0] {
		drv_idle,  // ce_n high, waiting for a start
		drv_shift, // bits on the wire
		drv_hold   // last low half before ce_n rises
	} drv_state_t;

	drv_state_t         state;
	logic [SHIFT_W-1:0] shift_q;     // outgoing bits, MSB on mosi
	logic [SHIFT_W-1:0] load_word;
	logic [CNT_W-1:0]   bits_left;   // bits still to clock incl. current
	logic [CNT_W-1:0]   load_bits;
	logic               rd_phase_en; // frame ends with a read byte
	logic               rise_half;   // sclk high, next edge is the falling one

	// frame layout left aligned, opcode then address then data byte
	always_comb begin
		load_word                    = '0;
		load_word[SHIFT_W-1 -: OW]   = xfer.opcode;
		load_bits                    = CNT_W'(OW);
		if (xfer.has_addr) begin
			load_word[SHIFT_W-OW-1 -: AW] = xfer.addr;
			load_bits                     = CNT_W'(OW + AW);
		end
		if (xfer.has_wdata || xfer.read) begin
			load_bits = load_bits + CNT_W'(DW); // read byte clocks zeros out
			if (xfer.has_wdata) begin
				if (xfer.has_addr) load_word[DW-1:0] = xfer.wdata;
				else load_word[SHIFT_W-OW-1 -: DW] = xfer.wdata;
			end
		end
	end

	assign rise_half = (state == drv_shift) && sclk;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= drv_idle;
			ce_n        <= 1'b1;
			sclk        <= 1'b0;
			mosi        <= 1'b0;
			xfer_busy   <= 1'b0;
			xfer_done   <= 1'b0;
			bits_left   <= '0;
			rd_phase_en <= 1'b0;
		end else begin
			xfer_done <= 1'b0;
			case (state)
				drv_idle: begin
					if (xfer_start) begin
						state       <= drv_shift;
						ce_n        <= 1'b0;                 // setup cycle, first bit out
						mosi        <= load_word[SHIFT_W-1];
						xfer_busy   <= 1'b1;
						bits_left   <= load_bits;
						rd_phase_en <= xfer.read;
					end
				end
				drv_shift: begin
					if (!sclk) begin
						sclk <= 1'b1; // device samples mosi here
					end else begin
						sclk      <= 1'b0;
						bits_left <= bits_left - 1'b1;
						if (bits_left == CNT_W'(1)) begin
							state <= drv_hold;
							mosi  <= 1'b0;
						end else begin
							mosi <= shift_q[SHIFT_W-2]; // next bit during low half
						end
					end
				end
				drv_hold: begin
					state     <= drv_idle;
					ce_n      <= 1'b1;
					xfer_busy <= 1'b0;
					xfer_done <= 1'b1; // same cycle ce_n returns high
				end
				default: state <= drv_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == drv_idle && xfer_start) shift_q <= load_word;
		else if (rise_half) shift_q <= shift_q << 1;
	end

	// only the trailing byte of a read frame lands here
	always_ff @(posedge clk) begin
		if (rise_half && rd_phase_en && bits_left <= CNT_W'(DW)) begin
			xfer_rdata <= {xfer_rdata[DW-2:0], miso};
		end
	end

endmodule

//--- src/psram_ctrl.sv
//************************************************************
// request queue with credit return, arbitrates the driver
// between the power-up sequence and client commands
//************************************************************
`timescale 1ns/1ps

module psram_ctrl #(
	parameter int REQ_DEPTH = 4,
	parameter int INIT_WAIT = 12800
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   req_valid,
	input  psram_pkg::psram_req_t  req,
	output logic                   credit,
	output logic                   rsp_valid,
	output psram_pkg::data_t       rsp_data,
	output logic                   init_done,
	output logic                   xfer_start,
	output psram_pkg::psram_xfer_t xfer,
	input  logic                   xfer_busy,
	input  logic                   xfer_done,
	input  psram_pkg::data_t       xfer_rdata
);
	import psram_pkg::*;

	localparam int PTR_W = $clog2(REQ_DEPTH);

	typedef enum logic [1:0] {
		ctrl_idle,  // driver belongs to the init sequencer
		ctrl_issue, // ready to launch the queue head
		ctrl_wait   // head transfer on the pins
	} ctrl_state_t;

	ctrl_state_t      state;
	psram_req_t       queue_mem [REQ_DEPTH]; // circular request store
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	credit_t          q_count;               // occupied entries
	psram_req_t       head;
	psram_xfer_t      head_xfer;
	psram_xfer_t      seq_xfer;
	logic             seq_start;
	logic             seq_busy;
	logic             seq_done;
	logic             q_empty;
	logic             issue;

	psram_init_seq #(
		.INIT_WAIT (INIT_WAIT)
	) i_psram_init_seq (
		.clk       (clk),
		.rst_n     (rst_n),
		.seq_busy  (seq_busy),
		.seq_done  (seq_done),
		.seq_start (seq_start),
		.seq_xfer  (seq_xfer),
		.init_done (init_done)
	);

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : ptr + 1'b1; // wraps for any depth
	endfunction

	assign seq_busy = xfer_busy;
	assign seq_done = xfer_done && (state == ctrl_idle); // done only seen by owner
	assign q_empty  = (q_count == '0);
	assign head     = queue_mem[rd_ptr];

	// byte read or byte write, always with address
	always_comb begin
		head_xfer           = '0;
		head_xfer.opcode    = head.write ? OP_WRITE : OP_READ;
		head_xfer.has_addr  = 1'b1;
		head_xfer.addr      = head.addr;
		head_xfer.has_wdata = head.write;
		head_xfer.wdata     = head.wdata;
		head_xfer.read      = !head.write;
	end

	assign issue      = (state == ctrl_issue) && !q_empty && !xfer_busy;
	assign xfer_start = (state == ctrl_idle) ? seq_start : issue;
	assign xfer       = (state == ctrl_idle) ? seq_xfer : head_xfer;

	// entry freed when its transfer ends
	assign credit    = (state == ctrl_wait) && xfer_done;
	assign rsp_valid = credit && !head.write;
	assign rsp_data  = xfer_rdata;

	always_ff @(posedge clk) begin
		if (req_valid) queue_mem[wr_ptr] <= req;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= ctrl_idle;
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			q_count <= '0;
		end else begin
			if (req_valid) wr_ptr <= ptr_next(wr_ptr);
			if (credit) rd_ptr <= ptr_next(rd_ptr);
			case ({req_valid, credit})
				2'b10:   q_count <= q_count + 1'b1;
				2'b01:   q_count <= q_count - 1'b1;
				default: ; // push and pop together, no change
			endcase
			case (state)
				ctrl_idle:  if (init_done) state <= ctrl_issue;
				ctrl_issue: if (issue) state <= ctrl_wait;
				ctrl_wait:  if (xfer_done) state <= ctrl_issue;
				default:    state <= ctrl_idle;
			endcase
		end
	end

endmodule

//--- src/psram_top.sv
//************************************************************
// PSRAM controller top, client request port and SPI pins
//************************************************************
`timescale 1ns/1ps

module psram_top #(
	parameter int REQ_DEPTH = 4,     // queue entries and client credits, 2 to 8
	parameter int INIT_WAIT = 12800  // power-up delay in clk cycles
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  req_valid,
	input  psram_pkg::psram_req_t req,
	output logic                  credit,
	output logic                  rsp_valid,
	output psram_pkg::data_t      rsp_data,
	output logic                  init_done,
	output logic                  ce_n,
	output logic                  sclk,
	output logic                  mosi,
	input  logic                  miso
);
	import psram_pkg::*;

	logic        xfer_start;
	logic        xfer_busy;
	logic        xfer_done;
	psram_xfer_t xfer;       // framed command toward the pins
	data_t       xfer_rdata; // byte shifted in on reads

	psram_ctrl #(
		.REQ_DEPTH (REQ_DEPTH),
		.INIT_WAIT (INIT_WAIT)
	) i_psram_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req        (req),
		.credit     (credit),
		.rsp_valid  (rsp_valid),
		.rsp_data   (rsp_data),
		.init_done  (init_done),
		.xfer_start (xfer_start),
		.xfer       (xfer),
		.xfer_busy  (xfer_busy),
		.xfer_done  (xfer_done),
		.xfer_rdata (xfer_rdata)
	);

	psram_spi_driver i_psram_spi_driver (
		.clk        (clk),
		.rst_n      (rst_n),
		.xfer_start (xfer_start),
		.xfer       (xfer),
		.xfer_busy  (xfer_busy),
		.xfer_done  (xfer_done),
		.xfer_rdata (xfer_rdata),
		.ce_n       (ce_n),
		.sclk       (sclk),
		.mosi       (mosi),
		.miso       (miso)
	);

endmodule

//--- sim/psram_model.sv
//************************************************************
// behavioral serial PSRAM on the SPI pins, mode 0 only
// flags any command seen before the RSTEN, RST pair
//************************************************************
`timescale 1ns/1ps

module psram_model (
	input  logic ce_n,
	input  logic sclk,
	input  logic mosi,
	output logic miso,
	output logic reset_seen, // RSTEN then RST arrived
	output logic order_err   // wrong command before the reset pair
);
	import psram_pkg::*;

	data_t       mem [256]; // low address byte picks the cell
	logic [39:0] frame;     // mosi bits, newest in bit 0
	int          bit_cnt;   // rising sclk edges in this frame
	opcode_t     opcode;
	addr_t       addr;
	data_t       rd_byte;   // latched once the address is in
	logic        rsten_seen;

	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i] = data_t'(i) ^ 8'hA5; // power-up contents
		end
		miso       = 1'b0;
		reset_seen = 1'b0;
		order_err  = 1'b0;
		rsten_seen = 1'b0;
		bit_cnt    = 0;
		opcode     = '0;
	end

	// device samples mosi on rising sclk
	always @(posedge sclk or posedge ce_n) begin
		if (ce_n) begin
			bit_cnt = 0; // frame closed
		end else begin
			frame   = {frame[38:0], mosi};
			bit_cnt = bit_cnt + 1;
			if (bit_cnt == 8) begin
				opcode = frame[7:0];
				if (!reset_seen) begin
					if (opcode == OP_RSTEN && !rsten_seen) rsten_seen = 1'b1;
					else if (opcode == OP_RST && rsten_seen) reset_seen = 1'b1;
					else order_err = 1'b1; // anything else breaks the pair
				end
			end else if (bit_cnt == 32) begin
				addr    = frame[23:0];
				rd_byte = mem[addr[7:0]];
			end else if (bit_cnt == 40 && opcode == OP_WRITE) begin
				mem[addr[7:0]] = frame[7:0]; // write byte complete
			end
		end
	end

	// read data goes out on falling sclk, MSB first
	always @(negedge sclk) begin
		if (!ce_n && opcode == OP_READ && bit_cnt >= 32 && bit_cnt < 40) begin
			miso <= rd_byte[39 - bit_cnt];
		end
	end

endmodule

//--- sim/psram_props.sv
//************************************************************
// concurrent checks on the SPI pins and client credits
// bound into psram_top below
//************************************************************
`timescale 1ns/1ps

module psram_props #(
	parameter int REQ_DEPTH = 4
) (
	input logic clk,
	input logic rst_n,
	input logic req_valid,
	input logic credit,
	input logic rsp_valid,
	input logic init_done,
	input logic ce_n,
	input logic sclk
);
	int avail;        // client credits rebuilt from port traffic
	int fail_cnt = 0; // failed checks, read at end of run

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) avail <= REQ_DEPTH;
		else avail <= avail - int'(req_valid) + int'(credit);
	end

	sclk_parked: assert property (@(posedge clk) disable iff (!rst_n) ce_n |-> !sclk)
		else begin
			$error("sclk high while ce_n is high");
			fail_cnt++;
		end
	req_has_credit: assert property (@(posedge clk) disable iff (!rst_n) req_valid |-> avail > 0)
		else begin
			$error("request sent with no credit left");
			fail_cnt++;
		end
	rsp_with_credit: assert property (@(posedge clk) disable iff (!rst_n) rsp_valid |-> credit)
		else begin
			$error("rsp_valid without a credit pulse");
			fail_cnt++;
		end
	init_sticky: assert property (@(posedge clk) disable iff (!rst_n) init_done |=> init_done)
		else begin
			$error("init_done fell after rising");
			fail_cnt++;
		end
	reset_quiet: assert property (@(posedge clk)
		$rose(rst_n) |-> ce_n && !credit && !rsp_valid && !init_done)
		else begin
			$error("outputs active right after reset");
			fail_cnt++;
		end

endmodule

bind psram_top psram_props #(
	.REQ_DEPTH (REQ_DEPTH)
) i_psram_props (
	.clk       (clk),
	.rst_n     (rst_n),
	.req_valid (req_valid),
	.credit    (credit),
	.rsp_valid (rsp_valid),
	.init_done (init_done),
	.ce_n      (ce_n),
	.sclk      (sclk)
);

//--- sim/tb_psram.sv
//************************************************************
// testbench for psram_top with the behavioral PSRAM on its pins
// checks power-up, read/write data, credits and ordering
//************************************************************
`timescale 1ns/1ps

module tb_psram;
	import psram_pkg::*;

	localparam int REQ_DEPTH = 4;
	localparam int INIT_WAIT = 40;
	localparam int INIT_LAT  = INIT_WAIT + 2 + 18 + 1 + 18 + 1; // reset release to init_done
	localparam int LIMIT     = 2000;                            // cycles allowed per wait

	logic       clk;
	logic       rst_n;
	logic       req_valid;
	psram_req_t req;
	logic       credit;
	logic       rsp_valid;
	data_t      rsp_data;
	logic       init_done;
	logic       ce_n;
	logic       sclk;
	logic       mosi;
	logic       miso;
	logic       model_reset_seen;
	logic       model_order_err;

	int    errors     = 0;
	int    sent_cnt   = 0; // requests handed to the DUT
	int    credit_cnt = 0; // credit pulses seen
	int    rsp_cnt    = 0;
	int    read_cnt   = 0;
	data_t sb [256];       // expected byte per address
	logic  written [256];
	data_t exp_q [$];      // read data in request order
	data_t exp_byte;

	psram_top #(
		.REQ_DEPTH (REQ_DEPTH),
		.INIT_WAIT (INIT_WAIT)
	) i_psram_top (.*);

	psram_model i_psram_model (
		.ce_n       (ce_n),
		.sclk       (sclk),
		.mosi       (mosi),
		.miso       (miso),
		.reset_seen (model_reset_seen),
		.order_err  (model_order_err)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic report_mismatch(input string sig, input int expected, input int actual);
		errors++;
		$display("error at %0t ns: %s expected %0h got %0h", $time, sig, expected, actual);
	endtask

	task automatic report_fail(input string what);
		errors++;
		$display("check failed at %0t ns: %s", $time, what);
	endtask

	task automatic end_run();
		int prop_fails;
		prop_fails = i_psram_top.i_psram_props.fail_cnt;
		errors     = errors + prop_fails;
		$display("closing: %0d errors (%0d from properties), %0d requests, %0d responses",
			errors, prop_fails, sent_cnt, rsp_cnt);
		if (errors == 0) $display("Finished with no errors");
		else $display("Finished with errors");
		$finish;
	endtask

	// called and returns at 1 ns after a rising edge
	task automatic send_req(input logic is_write, input addr_t addr, input data_t wdata);
		int n;
		n = 0;
		while (REQ_DEPTH - sent_cnt + credit_cnt <= 0 && n < LIMIT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (n >= LIMIT) begin
			report_fail("timeout waiting for a request credit");
		end else begin
			req_valid = 1'b1;
			req       = '{write: is_write, addr: addr, wdata: wdata};
			sent_cnt++;
			if (is_write) begin
				sb[addr[7:0]]      = wdata;
				written[addr[7:0]] = 1'b1;
			end else begin
				exp_q.push_back(sb[addr[7:0]]); // reflects every earlier write
				read_cnt++;
			end
			@(posedge clk);
			#1;
			req_valid = 1'b0;
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while ((credit_cnt != sent_cnt || exp_q.size() != 0) && n < LIMIT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (n >= LIMIT) begin
			report_fail("timeout waiting for credits to return");
		end
	endtask

	// credits and responses, sampled mid cycle
	always @(negedge clk) begin
		if (rst_n) begin
			if (credit) credit_cnt++;
			assert (REQ_DEPTH - sent_cnt + credit_cnt >= 0 && credit_cnt <= sent_cnt)
			else report_fail("client credit count outside 0 to REQ_DEPTH");
			if (rsp_valid) begin
				rsp_cnt++;
				if (exp_q.size() == 0) begin
					report_fail("read response with no read outstanding");
				end else begin
					exp_byte = exp_q.pop_front();
					assert (rsp_data == exp_byte)
					else report_mismatch("rsp_data", exp_byte, rsp_data);
				end
			end
		end
	end

	initial begin
		int    n;
		addr_t a;
		addr_t wr_addr [8];
		int    base_credit;
		int    base_rsp;
		int    base_reads;
		void'($urandom(98));
		rst_n     = 1'b0;
		req_valid = 1'b0;
		req       = '0;
		for (int i = 0; i < 256; i++) begin
			sb[i]      = data_t'(i) ^ 8'hA5; // model's power-up contents
			written[i] = 1'b0;
		end
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// power-up: exact latency, quiet pins during the wait
		n = 0;
		while (!init_done && n < LIMIT) begin
			@(posedge clk);
			#1;
			n++;
			if (n <= INIT_WAIT) assert (ce_n) else report_mismatch("ce_n", 1, ce_n);
			assert (!credit) else report_mismatch("credit", 0, credit);
		end
		if (!init_done) begin
			report_fail("timeout waiting for init_done");
		end
		assert (n == INIT_LAT) else report_mismatch("init_done latency", INIT_LAT, n);
		assert (ce_n) else report_mismatch("ce_n", 1, ce_n);
		assert (model_reset_seen) else report_fail("device never saw RSTEN then RST");
		assert (!model_order_err) else report_fail("device saw a command before reset");

		// random writes, then read them back
		for (int i = 0; i < 8; i++) begin
			wr_addr[i] = addr_t'($urandom % 256);
			send_req(1'b1, wr_addr[i], data_t'($urandom));
		end
		for (int i = 0; i < 8; i++) send_req(1'b0, wr_addr[i], '0);
		wait_drain();

		// never written addresses hold the fill pattern
		for (int i = 0; i < 4; i++) begin
			do a = addr_t'($urandom % 256); while (written[a[7:0]]);
			send_req(1'b0, a, '0);
		end
		wait_drain();

		// full burst of requests, every credit comes back
		base_credit = credit_cnt;
		base_rsp    = rsp_cnt;
		base_reads  = read_cnt;
		for (int i = 0; i < REQ_DEPTH; i++) begin
			send_req(i[0], addr_t'($urandom % 256), data_t'($urandom));
		end
		wait_drain();
		assert (credit_cnt - base_credit == REQ_DEPTH)
		else report_mismatch("credit pulses", REQ_DEPTH, credit_cnt - base_credit);
		assert (rsp_cnt - base_rsp == read_cnt - base_reads)
		else report_mismatch("rsp_valid pulses", read_cnt - base_reads, rsp_cnt - base_rsp);

		// write, read, write, read on one address, queue full
		a = addr_t'($urandom % 256);
		send_req(1'b1, a, data_t'($urandom));
		send_req(1'b0, a, '0);
		send_req(1'b1, a, data_t'($urandom));
		send_req(1'b0, a, '0);
		wait_drain();

		assert (rsp_cnt == read_cnt) else report_mismatch("rsp_valid pulses", read_cnt, rsp_cnt);
		assert (!model_order_err) else report_fail("device saw commands out of order");
		end_run();
	end

endmodule

//--- vlog.f
src/psram_pkg.sv
src/psram_init_seq.sv
src/psram_spi_driver.sv
src/psram_ctrl.sv
src/psram_top.sv
sim/psram_model.sv
sim/psram_props.sv
sim/tb_psram.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the PSRAM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_psram -f vlog.f -o tb_psram_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/tb_psram_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1
